// File: id_stage.f
+incdir+src
src/id_pkg.sv
src/id_dec_if.sv
src/id_stage_reg.sv
src/id_decoder.sv
src/id_gpr_file.sv
src/id_branch_resolver.sv
src/id_stage.sv
test/id_stage_checker.sv
test/tb_id_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f id_stage.f \
  --top-module tb_id_stage \
  -o sim_id_stage

./obj_dir/sim_id_stage | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

// File: src/id_branch_resolver.sv
// id_branch_resolver: branch compare, jump target and redirect to fetch
`timescale 1ns/10ps
`default_nettype none

`include "id_consts.svh"

module id_branch_resolver import id_pkg::*; (
  id_dec_if.bru  bru,
  input  wire    i_valid_go,
  input  pc_t    i_pc,
  input  xlen_t  i_rs1_data,
  input  xlen_t  i_rs2_data,
  output logic   o_br_taken,
  output pc_t    o_br_target
);

  logic  cond;
  logic  eq, lt, ltu;
  xlen_t jalr_sum;

  assign eq  = (i_rs1_data == i_rs2_data);
  assign lt  = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign ltu = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (bru.br_func)
      3'b000:  cond = eq;    // beq
      3'b001:  cond = !eq;   // bne
      3'b100:  cond = lt;    // blt
      3'b101:  cond = !lt;   // bge
      3'b110:  cond = ltu;   // bltu
      3'b111:  cond = !ltu;  // bgeu
      default: cond = 1'b0;
    endcase
  end

  assign jalr_sum = i_rs1_data + bru.imm;

  // only redirect for an instruction that actually leaves decode
  assign o_br_taken = i_valid_go && (bru.is_jal || bru.is_jalr || (bru.br_en && cond));

  assign o_br_target = bru.is_jalr ? {jalr_sum[`ID_XLEN-1:1], 1'b0}
                                   : i_pc + bru.imm;

endmodule

`default_nettype wire

// File: src/id_consts.svh
// decode stage constants: widths, register count, opcodes, alu/mem op codes, ebreak source
`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

`define ID_XLEN        64
`define ID_INST_W      32
`define ID_GPR_ADDR_W  5
`define ID_NUM_GPR     32
`define ID_EBREAK_SRC  5'd10  // a0

// opcodes, base integer subset
`define ID_OPC_LUI       7'b0110111
`define ID_OPC_AUIPC     7'b0010111
`define ID_OPC_JAL       7'b1101111
`define ID_OPC_JALR      7'b1100111
`define ID_OPC_BRANCH    7'b1100011
`define ID_OPC_LOAD      7'b0000011
`define ID_OPC_STORE     7'b0100011
`define ID_OPC_OP_IMM    7'b0010011
`define ID_OPC_OP        7'b0110011
`define ID_OPC_OP_IMM_32 7'b0011011
`define ID_OPC_OP_32     7'b0111011
`define ID_OPC_SYSTEM    7'b1110011
`define ID_INST_EBREAK   32'h0010_0073

`define ID_ALU_ADD   4'd0
`define ID_ALU_SUB   4'd1
`define ID_ALU_SLL   4'd2
`define ID_ALU_SLT   4'd3
`define ID_ALU_SLTU  4'd4
`define ID_ALU_XOR   4'd5
`define ID_ALU_SRL   4'd6
`define ID_ALU_SRA   4'd7
`define ID_ALU_OR    4'd8
`define ID_ALU_AND   4'd9
`define ID_ALU_COPY2 4'd10  // pass operand 2, lui

// load/store funct3
`define ID_MEM_B  3'b000
`define ID_MEM_H  3'b001
`define ID_MEM_W  3'b010
`define ID_MEM_D  3'b011
`define ID_MEM_BU 3'b100
`define ID_MEM_HU 3'b101
`define ID_MEM_WU 3'b110

`define ID_SRC2_RS2  2'd0
`define ID_SRC2_IMM  2'd1
`define ID_SRC2_FOUR 2'd2

`endif

// File: src/id_dec_if.sv
// id_dec_if: decoder results toward register file, interlock and branch resolver
`timescale 1ns/10ps
`default_nettype none

interface id_dec_if import id_pkg::*; ();

  gpr_addr_t rs1;
  gpr_addr_t rs2;
  xlen_t     imm;
  logic      br_en;
  br_func_t  br_func;
  logic      is_jal;
  logic      is_jalr;
  logic      is_ebreak;

  modport dec (
    output rs1, rs2, imm, br_en, br_func, is_jal, is_jalr, is_ebreak
  );

  modport gpr (input rs1, rs2);

  modport hazard (input rs1, rs2, is_ebreak);

  modport bru (input imm, br_en, br_func, is_jal, is_jalr);

endinterface

`default_nettype wire

// File: src/id_decoder.sv
// id_decoder: rv64i field extraction, immediates and control decode
`timescale 1ns/10ps
`default_nettype none

`include "id_consts.svh"

module id_decoder import id_pkg::*; (
  input  inst_t      i_inst,
  id_dec_if.dec      dec,
  output gpr_addr_t  o_rd,
  output alu_op_t    o_alu_op,
  output logic       o_alu_src1_pc,
  output src2_sel_t  o_alu_src2_sel,
  output logic       o_alu_word,
  output logic       o_gpr_wen,
  output logic       o_mem_ren,
  output logic       o_mem_wen,
  output mem_op_t    o_mem_op,
  output logic       o_invalid_inst
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  xlen_t      imm;
  logic       use_rs1, use_rs2;
  logic       br_en, is_jal, is_jalr, is_ebreak;
  logic       sh_bad, op_bad, w_bad;

  // shared by op, op-imm and their word forms
  function automatic alu_op_t alu_from_f3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_from_f3 = alt ? `ID_ALU_SUB : `ID_ALU_ADD;
      3'b001:  alu_from_f3 = `ID_ALU_SLL;
      3'b010:  alu_from_f3 = `ID_ALU_SLT;
      3'b011:  alu_from_f3 = `ID_ALU_SLTU;
      3'b100:  alu_from_f3 = `ID_ALU_XOR;
      3'b101:  alu_from_f3 = alt ? `ID_ALU_SRA : `ID_ALU_SRL;
      3'b110:  alu_from_f3 = `ID_ALU_OR;
      default: alu_from_f3 = `ID_ALU_AND;
    endcase
  endfunction

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{(`ID_XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(`ID_XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(`ID_XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{(`ID_XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(`ID_XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // illegal shift/funct7 patterns
  assign sh_bad = (funct3 == 3'b001 && i_inst[31:26] != '0) ||
                  (funct3 == 3'b101 && {i_inst[31], i_inst[29:26]} != '0);
  assign op_bad = !(funct7 == 7'b0 || (funct7 == 7'b0100000 && funct3 inside {3'b000, 3'b101}));
  assign w_bad  = !(funct3 inside {3'b000, 3'b001, 3'b101});

  always_comb begin
    o_alu_op       = `ID_ALU_ADD;
    o_alu_src1_pc  = 1'b0;
    o_alu_src2_sel = `ID_SRC2_RS2;
    o_alu_word     = 1'b0;
    o_gpr_wen      = 1'b0;
    o_mem_ren      = 1'b0;
    o_mem_wen      = 1'b0;
    o_invalid_inst = 1'b0;
    imm            = imm_i;
    use_rs1        = 1'b0;
    use_rs2        = 1'b0;
    br_en          = 1'b0;
    is_jal         = 1'b0;
    is_jalr        = 1'b0;
    is_ebreak      = 1'b0;
    case (opcode)
      `ID_OPC_LUI: begin
        o_alu_op = `ID_ALU_COPY2;
        o_alu_src2_sel = `ID_SRC2_IMM;
        imm = imm_u;
        o_gpr_wen = 1'b1;
      end
      `ID_OPC_AUIPC: begin
        o_alu_src1_pc = 1'b1;
        o_alu_src2_sel = `ID_SRC2_IMM;
        imm = imm_u;
        o_gpr_wen = 1'b1;
      end
      `ID_OPC_JAL, `ID_OPC_JALR: begin
        o_alu_src1_pc = 1'b1;
        o_alu_src2_sel = `ID_SRC2_FOUR;  // link = pc + 4
        o_gpr_wen = 1'b1;
        is_jal = (opcode == `ID_OPC_JAL);
        is_jalr = (opcode == `ID_OPC_JALR);
        imm = is_jal ? imm_j : imm_i;
        use_rs1 = is_jalr;
        o_invalid_inst = is_jalr && funct3 != 3'b000;
      end
      `ID_OPC_BRANCH: begin
        imm = imm_b;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        br_en = 1'b1;
        o_invalid_inst = (funct3[2:1] == 2'b01);
      end
      `ID_OPC_LOAD: begin
        o_alu_src2_sel = `ID_SRC2_IMM;
        use_rs1 = 1'b1;
        o_mem_ren = 1'b1;
        o_gpr_wen = 1'b1;
        o_invalid_inst = !(funct3 inside {`ID_MEM_B, `ID_MEM_H, `ID_MEM_W, `ID_MEM_D,
                                          `ID_MEM_BU, `ID_MEM_HU, `ID_MEM_WU});
      end
      `ID_OPC_STORE: begin
        o_alu_src2_sel = `ID_SRC2_IMM;
        imm = imm_s;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        o_mem_wen = 1'b1;
        o_invalid_inst = !(funct3 inside {`ID_MEM_B, `ID_MEM_H, `ID_MEM_W, `ID_MEM_D});
      end
      `ID_OPC_OP_IMM, `ID_OPC_OP_IMM_32: begin
        o_alu_src2_sel = `ID_SRC2_IMM;
        o_alu_word = (opcode == `ID_OPC_OP_IMM_32);
        o_alu_op = alu_from_f3(funct3, funct3 == 3'b101 && i_inst[30]);
        use_rs1 = 1'b1;
        o_gpr_wen = 1'b1;
        // word shifts only have a 5-bit shamt
        o_invalid_inst = sh_bad || (o_alu_word && (w_bad || (funct3 != 3'b000 && i_inst[25])));
      end
      `ID_OPC_OP, `ID_OPC_OP_32: begin
        o_alu_word = (opcode == `ID_OPC_OP_32);
        o_alu_op = alu_from_f3(funct3, i_inst[30]);
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        o_gpr_wen = 1'b1;
        o_invalid_inst = op_bad || (o_alu_word && w_bad);
      end
      `ID_OPC_SYSTEM: begin
        is_ebreak = (i_inst == `ID_INST_EBREAK);
        o_invalid_inst = !is_ebreak;
      end
      default: o_invalid_inst = 1'b1;
    endcase
    if (o_invalid_inst) begin
      o_gpr_wen = 1'b0;
      o_mem_ren = 1'b0;
      o_mem_wen = 1'b0;
      br_en     = 1'b0;
      is_jal    = 1'b0;
      is_jalr   = 1'b0;
      use_rs1   = 1'b0;
      use_rs2   = 1'b0;
    end
  end

  assign dec.rs1       = is_ebreak ? `ID_EBREAK_SRC : (use_rs1 ? i_inst[19:15] : '0);
  assign dec.rs2       = use_rs2 ? i_inst[24:20] : '0;
  assign dec.imm       = imm;
  assign dec.br_en     = br_en;
  assign dec.br_func   = funct3;
  assign dec.is_jal    = is_jal;
  assign dec.is_jalr   = is_jalr;
  assign dec.is_ebreak = is_ebreak;

  assign o_rd     = o_gpr_wen ? i_inst[11:7] : '0;  // 0 means no write downstream
  assign o_mem_op = funct3;

endmodule

`default_nettype wire

// File: src/id_gpr_file.sv
// id_gpr_file: 32x64 general purpose registers, two async reads, one write
`timescale 1ns/10ps
`default_nettype none

`include "id_consts.svh"

module id_gpr_file import id_pkg::*; (
  input  wire        i_clk,
  input  wire        i_rst_n,
  id_dec_if.gpr      gpr,
  // write-back port
  input  wire        i_wen,
  input  gpr_addr_t  i_waddr,
  input  xlen_t      i_wdata,
  output xlen_t      o_rs1_data,
  output xlen_t      o_rs2_data
);

  xlen_t regs [`ID_NUM_GPR];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `ID_NUM_GPR; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // no bypass, a write shows up after the edge
  assign o_rs1_data = (gpr.rs1 == '0) ? '0 : regs[gpr.rs1];
  assign o_rs2_data = (gpr.rs2 == '0) ? '0 : regs[gpr.rs2];

endmodule

`default_nettype wire

// File: src/id_pkg.sv
// id_pkg: shared vector typedefs for the decode stage
`default_nettype none

`include "id_consts.svh"

package id_pkg;

  // data and address
  typedef logic [`ID_XLEN-1:0] xlen_t;
  typedef logic [`ID_XLEN-1:0] pc_t;
  typedef logic [`ID_INST_W-1:0] inst_t;

  typedef logic [`ID_GPR_ADDR_W-1:0] gpr_addr_t;

  // control fields handed to execute
  typedef logic [3:0] alu_op_t;
  typedef logic [2:0] mem_op_t;   // load/store funct3
  typedef logic [2:0] br_func_t;  // branch funct3
  typedef logic [1:0] src2_sel_t;

endpackage

`default_nettype wire

// File: src/id_stage.sv
// id_stage: decode stage top, stage register, decoder, register file, branch resolver
`timescale 1ns/10ps
`default_nettype none

module id_stage import id_pkg::*; (
  input  wire        i_clk,
  input  wire        i_rst_n,
  // fetch
  input  wire        i_fs_to_ds_valid,
  input  inst_t      i_fs_inst,
  input  pc_t        i_fs_pc,
  output logic       o_ds_allowin,
  // execute
  input  wire        i_es_allowin,
  output logic       o_ds_to_es_valid,
  output inst_t      o_ds_inst,
  output pc_t        o_ds_pc,
  output xlen_t      o_rs1_data,
  output xlen_t      o_rs2_data,
  output xlen_t      o_imm,
  output gpr_addr_t  o_rd,
  output alu_op_t    o_alu_op,
  output logic       o_alu_src1_pc,
  output src2_sel_t  o_alu_src2_sel,
  output logic       o_alu_word,
  output logic       o_gpr_wen,
  output logic       o_mem_ren,
  output logic       o_mem_wen,
  output mem_op_t    o_mem_op,
  output logic       o_ebreak,
  output logic       o_invalid_inst,
  // hazard inputs
  input  gpr_addr_t  i_es_rd,
  input  gpr_addr_t  i_ms_rd,
  input  gpr_addr_t  i_ws_rd,
  // write-back
  input  wire        i_wb_wen,
  input  gpr_addr_t  i_wb_addr,
  input  xlen_t      i_wb_data,
  // redirect
  output logic       o_br_taken,
  output pc_t        o_br_target
);

  id_dec_if dec_if ();

  id_stage_reg u_stage_reg (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_fs_inst        (i_fs_inst),
    .i_fs_pc          (i_fs_pc),
    .o_ds_allowin     (o_ds_allowin),
    .i_es_allowin     (i_es_allowin),
    .o_ds_valid_go    (o_ds_to_es_valid),
    .i_es_rd          (i_es_rd),
    .i_ms_rd          (i_ms_rd),
    .i_ws_rd          (i_ws_rd),
    .hz               (dec_if.hazard),
    .o_inst           (o_ds_inst),
    .o_pc             (o_ds_pc)
  );

  id_decoder u_decoder (
    .i_inst         (o_ds_inst),
    .dec            (dec_if.dec),
    .o_rd           (o_rd),
    .o_alu_op       (o_alu_op),
    .o_alu_src1_pc  (o_alu_src1_pc),
    .o_alu_src2_sel (o_alu_src2_sel),
    .o_alu_word     (o_alu_word),
    .o_gpr_wen      (o_gpr_wen),
    .o_mem_ren      (o_mem_ren),
    .o_mem_wen      (o_mem_wen),
    .o_mem_op       (o_mem_op),
    .o_invalid_inst (o_invalid_inst)
  );

  id_gpr_file u_gpr_file (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .gpr        (dec_if.gpr),
    .i_wen      (i_wb_wen),
    .i_waddr    (i_wb_addr),
    .i_wdata    (i_wb_data),
    .o_rs1_data (o_rs1_data),
    .o_rs2_data (o_rs2_data)
  );

  id_branch_resolver u_bru (
    .bru         (dec_if.bru),
    .i_valid_go  (o_ds_to_es_valid),
    .i_pc        (o_ds_pc),
    .i_rs1_data  (o_rs1_data),
    .i_rs2_data  (o_rs2_data),
    .o_br_taken  (o_br_taken),
    .o_br_target (o_br_target)
  );

  assign o_imm    = dec_if.imm;
  assign o_ebreak = dec_if.is_ebreak;

endmodule

`default_nettype wire

// File: src/id_stage_reg.sv
// id_stage_reg: stage valid, instruction/pc register, raw interlock and allowin
`timescale 1ns/10ps
`default_nettype none

`include "id_consts.svh"

module id_stage_reg import id_pkg::*; (
  input  wire        i_clk,
  input  wire        i_rst_n,
  // fetch side
  input  wire        i_fs_to_ds_valid,
  input  inst_t      i_fs_inst,
  input  pc_t        i_fs_pc,
  output logic       o_ds_allowin,
  // execute side
  input  wire        i_es_allowin,
  output logic       o_ds_valid_go,
  // destinations still in flight
  input  gpr_addr_t  i_es_rd,
  input  gpr_addr_t  i_ms_rd,
  input  gpr_addr_t  i_ws_rd,
  id_dec_if.hazard   hz,
  output inst_t      o_inst,
  output pc_t        o_pc
);

  logic ds_valid;
  logic hazard;

  // rd of a later stage collides with a source of the held instruction
  function automatic logic rd_hit(
    input gpr_addr_t rd,
    input gpr_addr_t rs1,
    input gpr_addr_t rs2,
    input logic      ebreak
  );
    if (rd == '0) begin
      rd_hit = 1'b0;  // x0 never creates a dependency
    end else if (ebreak) begin
      rd_hit = (rd == `ID_EBREAK_SRC);
    end else begin
      rd_hit = (rd == rs1) || (rd == rs2);
    end
  endfunction

  assign hazard = rd_hit(i_es_rd, hz.rs1, hz.rs2, hz.is_ebreak) ||
                  rd_hit(i_ms_rd, hz.rs1, hz.rs2, hz.is_ebreak) ||
                  rd_hit(i_ws_rd, hz.rs1, hz.rs2, hz.is_ebreak);

  assign o_ds_valid_go = ds_valid && !hazard;
  assign o_ds_allowin  = !ds_valid || (!hazard && i_es_allowin);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      o_inst <= i_fs_inst;
      o_pc   <= i_fs_pc;
    end
  end

endmodule

`default_nettype wire

// File: test/id_stage_checker.sv
// assertions on the decode stage handshake, reset and redirect, bound to the top level
`timescale 1ns/10ps
`default_nettype none

`include "id_consts.svh"

module id_stage_checker import id_pkg::*; (
  input wire   i_clk,
  input wire   i_rst_n,
  input wire   i_fs_to_ds_valid,
  input wire   i_es_allowin,
  input wire   o_ds_allowin,
  input wire   o_ds_to_es_valid,
  input wire   o_br_taken,
  input inst_t o_ds_inst
);

  logic full;  // stage holds an instruction

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      full <= 1'b0;
    end else if (o_ds_allowin) begin
      full <= i_fs_to_ds_valid;
    end
  end

  a_quiet_in_reset: assert property (@(posedge i_clk) !i_rst_n |-> !o_ds_to_es_valid)
    else $error("ds_to_es_valid high while reset is asserted");

  // a redirect only comes from a valid branch or jump
  a_taken_needs_valid: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    o_br_taken |-> o_ds_to_es_valid &&
                   o_ds_inst[6:0] inside {`ID_OPC_BRANCH, `ID_OPC_JAL, `ID_OPC_JALR})
    else $error("br_taken without a valid branch or jump");

  a_hold_under_stall: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (o_ds_to_es_valid && !i_es_allowin) |=> $stable(o_ds_inst))
    else $error("ds_inst changed while execute refused it");

  a_empty_allows: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) !full |-> o_ds_allowin)
    else $error("ds_allowin low with an empty stage");

endmodule

`default_nettype wire

// File: test/tb_id_stage.sv
// decode stage testbench: clock, reset, lfsr, encoders, compare tasks, directed tests, timeout
`timescale 1ns/10ps
`default_nettype none

`include "id_consts.svh"

module tb_id_stage import id_pkg::*; ();

  localparam int MAX_CYCLES = 2000;  // tests take about 300

  logic      i_clk;
  logic      i_rst_n;
  logic      i_fs_to_ds_valid;
  inst_t     i_fs_inst;
  pc_t       i_fs_pc;
  logic      o_ds_allowin;
  logic      i_es_allowin;
  logic      o_ds_to_es_valid;
  inst_t     o_ds_inst;
  pc_t       o_ds_pc;
  xlen_t     o_rs1_data, o_rs2_data, o_imm;
  gpr_addr_t o_rd, i_es_rd, i_ms_rd, i_ws_rd, i_wb_addr;
  alu_op_t   o_alu_op;
  logic      o_alu_src1_pc, o_alu_word, o_gpr_wen, o_mem_ren, o_mem_wen;
  logic      o_ebreak, o_invalid_inst;
  src2_sel_t o_alu_src2_sel;
  mem_op_t   o_mem_op;
  logic      i_wb_wen;
  xlen_t     i_wb_data;
  logic      o_br_taken;
  pc_t       o_br_target;

  xlen_t       model [`ID_NUM_GPR];  // expected register contents
  logic [15:0] lfsr_state = 16'd8;
  string       test_name;
  int          n_checks;
  int          n_errors;
  int          cycles;

  id_stage u_dut (.*);

  bind id_stage id_stage_checker u_checker (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_es_allowin     (i_es_allowin),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_br_taken       (o_br_taken),
    .o_ds_inst        (o_ds_inst)
  );

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic xlen_t rand_bits(input int n);
    xlen_t v;
    int    i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[`ID_XLEN-2:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // rv64i encoders
  function automatic inst_t enc_r(input logic [6:0] f7, input gpr_addr_t rs2,
                                  input gpr_addr_t rs1, input logic [2:0] f3,
                                  input gpr_addr_t rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic inst_t enc_i(input logic [11:0] imm, input gpr_addr_t rs1,
                                  input logic [2:0] f3, input gpr_addr_t rd,
                                  input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic inst_t enc_s(input logic [11:0] imm, input gpr_addr_t rs2,
                                  input gpr_addr_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], `ID_OPC_STORE};
  endfunction

  function automatic inst_t enc_b(input logic [12:0] off, input gpr_addr_t rs2,
                                  input gpr_addr_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `ID_OPC_BRANCH};
  endfunction

  function automatic inst_t enc_u(input logic [19:0] imm, input gpr_addr_t rd,
                                  input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic inst_t enc_j(input logic [20:0] off, input gpr_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, `ID_OPC_JAL};
  endfunction

  task automatic check_xlen(input string what, input xlen_t exp, input xlen_t act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("error: %s %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_pc(input string what, input pc_t exp, input pc_t act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("error: %s %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_inst(input string what, input inst_t exp, input inst_t act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("error: %s %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_addr(input string what, input gpr_addr_t exp, input gpr_addr_t act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("error: %s %s expected %0d actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_alu_op(input string what, input alu_op_t exp, input alu_op_t act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("error: %s %s expected %0d actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_sel(input string what, input src2_sel_t exp, input src2_sel_t act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("error: %s %s expected %0d actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_mem_op(input string what, input mem_op_t exp, input mem_op_t act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("error: %s %s expected %b actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("error: %s %s expected %b actual %b", test_name, what, exp, act);
    end
  endtask

  // controls of a legal instruction
  task automatic check_ctrl(input alu_op_t alu, input logic s1pc, input src2_sel_t s2,
                            input logic word, input logic wen, input logic ren,
                            input logic mwen);
    check_alu_op("alu_op", alu, o_alu_op);
    check_bit("alu_src1_pc", s1pc, o_alu_src1_pc);
    check_sel("alu_src2_sel", s2, o_alu_src2_sel);
    check_bit("alu_word", word, o_alu_word);
    check_bit("gpr_wen", wen, o_gpr_wen);
    check_bit("mem_ren", ren, o_mem_ren);
    check_bit("mem_wen", mwen, o_mem_wen);
    check_bit("invalid_inst", 1'b0, o_invalid_inst);
  endtask

  task automatic gpr_write(input gpr_addr_t a, input xlen_t d);
    @(posedge i_clk);
    i_wb_wen  <= 1'b1;
    i_wb_addr <= a;
    i_wb_data <= d;
    @(posedge i_clk);
    i_wb_wen <= 1'b0;
    if (a != '0) begin
      model[a] = d;  // x0 stays zero
    end
  endtask

  // present one fetch, wait for allowin, return mid-cycle after the capture edge
  task automatic send(input inst_t inst, input pc_t pc);
    @(posedge i_clk);
    i_fs_to_ds_valid <= 1'b1;
    i_fs_inst        <= inst;
    i_fs_pc          <= pc;
    @(negedge i_clk);
    while (!o_ds_allowin) begin
      @(negedge i_clk);
    end
    @(posedge i_clk);
    i_fs_to_ds_valid <= 1'b0;
    @(negedge i_clk);
  endtask

  task automatic check_rr(input gpr_addr_t rs1, input gpr_addr_t rs2, input gpr_addr_t rd,
                          input logic sub);
    send(enc_r(sub ? 7'b0100000 : 7'b0000000, rs2, rs1, 3'b000, rd, `ID_OPC_OP),
         64'h0000_0000_8000_0000);
    check_bit("ds_to_es_valid", 1'b1, o_ds_to_es_valid);
    check_xlen("rs1_data", model[rs1], o_rs1_data);
    check_xlen("rs2_data", model[rs2], o_rs2_data);
    check_addr("rd", rd, o_rd);
    check_alu_op("alu_op", sub ? `ID_ALU_SUB : `ID_ALU_ADD, o_alu_op);
    check_bit("gpr_wen", 1'b1, o_gpr_wen);
  endtask

  task automatic test_gpr_read();
    test_name = "gpr_read";
    @(negedge i_clk);
    check_bit("ds_to_es_valid", 1'b0, o_ds_to_es_valid);
    check_bit("ds_allowin", 1'b1, o_ds_allowin);
    gpr_write(5'd1, rand_bits(64));
    gpr_write(5'd5, rand_bits(64));
    gpr_write(5'd10, rand_bits(64));
    gpr_write(5'd17, rand_bits(64));
    gpr_write(5'd31, rand_bits(64));
    gpr_write(5'd0, rand_bits(64));
    check_rr(5'd1, 5'd5, 5'd3, 1'b0);
    check_rr(5'd17, 5'd0, 5'd7, 1'b1);
    check_rr(5'd31, 5'd10, 5'd9, 1'b0);
    check_rr(5'd0, 5'd17, 5'd4, 1'b1);
  endtask

  task automatic test_formats();
    pc_t pc;
    test_name = "formats";
    pc = 64'h0000_0000_8000_0100;
    send(enc_u(20'habcde, 5'd4, `ID_OPC_LUI), pc);
    check_xlen("imm", 64'hffff_ffff_abcd_e000, o_imm);
    check_ctrl(`ID_ALU_COPY2, 1'b0, `ID_SRC2_IMM, 1'b0, 1'b1, 1'b0, 1'b0);
    check_addr("rd", 5'd4, o_rd);
    check_bit("ebreak", 1'b0, o_ebreak);
    send(enc_u(20'h12345, 5'd6, `ID_OPC_AUIPC), pc);
    check_xlen("imm", 64'h0000_0000_1234_5000, o_imm);
    check_ctrl(`ID_ALU_ADD, 1'b1, `ID_SRC2_IMM, 1'b0, 1'b1, 1'b0, 1'b0);
    send(enc_i(12'hf9c, 5'd1, 3'b000, 5'd8, `ID_OPC_OP_IMM), pc);  // addi -100
    check_xlen("imm", 64'hffff_ffff_ffff_ff9c, o_imm);
    check_xlen("rs1_data", model[1], o_rs1_data);
    check_ctrl(`ID_ALU_ADD, 1'b0, `ID_SRC2_IMM, 1'b0, 1'b1, 1'b0, 1'b0);
    send(enc_i(12'h403, 5'd5, 3'b101, 5'd8, `ID_OPC_OP_IMM_32), pc);  // sraiw 3
    check_xlen("imm", 64'h0000_0000_0000_0403, o_imm);
    check_ctrl(`ID_ALU_SRA, 1'b0, `ID_SRC2_IMM, 1'b1, 1'b1, 1'b0, 1'b0);
    send(enc_i(12'h7f8, 5'd17, `ID_MEM_D, 5'd12, `ID_OPC_LOAD), pc);
    check_xlen("imm", 64'h0000_0000_0000_07f8, o_imm);
    check_ctrl(`ID_ALU_ADD, 1'b0, `ID_SRC2_IMM, 1'b0, 1'b1, 1'b1, 1'b0);
    check_mem_op("mem_op", `ID_MEM_D, o_mem_op);
    check_addr("rd", 5'd12, o_rd);
    send(enc_s(12'h804, 5'd5, 5'd31, `ID_MEM_W), pc);
    check_xlen("imm", 64'hffff_ffff_ffff_f804, o_imm);
    check_ctrl(`ID_ALU_ADD, 1'b0, `ID_SRC2_IMM, 1'b0, 1'b0, 1'b0, 1'b1);
    check_mem_op("mem_op", `ID_MEM_W, o_mem_op);
    check_xlen("rs2_data", model[5], o_rs2_data);
    send(32'h0010_0073, pc);
    check_bit("ebreak", 1'b1, o_ebreak);
    check_bit("invalid_inst", 1'b0, o_invalid_inst);
    check_bit("gpr_wen", 1'b0, o_gpr_wen);
    check_xlen("rs1_data", model[10], o_rs1_data);  // a0
    send(32'h0000_007f, pc);
    check_bit("invalid_inst", 1'b1, o_invalid_inst);
    check_bit("gpr_wen", 1'b0, o_gpr_wen);
    check_bit("mem_ren", 1'b0, o_mem_ren);
    check_bit("mem_wen", 1'b0, o_mem_wen);
  endtask

  task automatic branch_case(input logic [2:0] f3, input gpr_addr_t rs1,
                             input gpr_addr_t rs2, input pc_t pc);
    xlen_t       r;
    xlen_t       a;
    xlen_t       b;
    logic [12:0] off;
    logic        taken;
    r   = rand_bits(12);
    off = {r[11:0], 1'b0};
    a   = model[rs1];
    b   = model[rs2];
    case (f3)
      3'b000:  taken = (a == b);
      3'b001:  taken = (a != b);
      3'b100:  taken = ($signed(a) < $signed(b));
      3'b101:  taken = ($signed(a) >= $signed(b));
      3'b110:  taken = (a < b);
      3'b111:  taken = (a >= b);
      default: taken = 1'b0;
    endcase
    send(enc_b(off, rs2, rs1, f3), pc);
    check_bit("br_taken", taken, o_br_taken);
    if (taken) begin
      check_pc("br_target", pc + {{51{off[12]}}, off}, o_br_target);
    end
  endtask

  task automatic test_branch();
    pc_t   pc;
    xlen_t r;
    xlen_t tgt;
    int    f;
    test_name = "branch";
    pc = 64'h0000_0000_8000_2000;
    r = rand_bits(64);
    gpr_write(5'd20, r);
    gpr_write(5'd21, r);  // equal pair
    gpr_write(5'd22, rand_bits(64) | 64'h8000_0000_0000_0000);
    gpr_write(5'd23, rand_bits(64) & 64'h7fff_ffff_ffff_ffff);
    for (f = 0; f < 8; f++) begin
      if (f != 2 && f != 3) begin
        branch_case(f[2:0], 5'd20, 5'd21, pc);
        branch_case(f[2:0], 5'd22, 5'd23, pc + 64'd4);
        branch_case(f[2:0], 5'd23, 5'd22, pc + 64'd8);
        pc = pc + 64'd16;
      end
    end
    r = rand_bits(20);
    send(enc_j({r[19:0], 1'b0}, 5'd1), pc);
    check_bit("br_taken", 1'b1, o_br_taken);
    check_pc("br_target", pc + {{43{r[19]}}, r[19:0], 1'b0}, o_br_target);
    check_addr("rd", 5'd1, o_rd);
    check_ctrl(`ID_ALU_ADD, 1'b1, `ID_SRC2_FOUR, 1'b0, 1'b1, 1'b0, 1'b0);
    r = rand_bits(12);
    send(enc_i(r[11:0], 5'd22, 3'b000, 5'd1, `ID_OPC_JALR), pc);
    tgt = model[22] + {{52{r[11]}}, r[11:0]};
    tgt[0] = 1'b0;
    check_bit("br_taken", 1'b1, o_br_taken);
    check_pc("br_target", tgt, o_br_target);
    check_ctrl(`ID_ALU_ADD, 1'b1, `ID_SRC2_FOUR, 1'b0, 1'b1, 1'b0, 1'b0);
  endtask

  task automatic test_interlock();
    inst_t add;
    test_name = "interlock";
    add = enc_r(7'd0, 5'd5, 5'd1, 3'b000, 5'd3, `ID_OPC_OP);
    @(posedge i_clk);
    i_es_rd <= 5'd5;
    send(add, 64'h0000_0000_8000_3000);
    check_bit("ds_to_es_valid es", 1'b0, o_ds_to_es_valid);
    check_bit("ds_allowin es", 1'b0, o_ds_allowin);
    @(posedge i_clk);
    i_es_rd <= 5'd0;
    i_ms_rd <= 5'd5;
    @(negedge i_clk);
    check_bit("ds_to_es_valid ms", 1'b0, o_ds_to_es_valid);
    check_bit("ds_allowin ms", 1'b0, o_ds_allowin);
    @(posedge i_clk);
    i_ms_rd <= 5'd0;
    i_ws_rd <= 5'd5;
    @(negedge i_clk);
    check_bit("ds_to_es_valid ws", 1'b0, o_ds_to_es_valid);
    check_bit("ds_allowin ws", 1'b0, o_ds_allowin);
    check_inst("ds_inst held", add, o_ds_inst);
    @(posedge i_clk);
    i_ws_rd <= 5'd0;
    @(negedge i_clk);
    check_bit("ds_to_es_valid cleared", 1'b1, o_ds_to_es_valid);
    check_inst("ds_inst issued", add, o_ds_inst);
    // x0 sources never wait
    @(posedge i_clk);
    i_ms_rd <= 5'd7;
    send(enc_i(12'h001, 5'd0, 3'b000, 5'd2, `ID_OPC_OP_IMM), 64'h0000_0000_8000_3004);
    check_bit("ds_to_es_valid rd0", 1'b1, o_ds_to_es_valid);
    @(posedge i_clk);
    i_ms_rd <= 5'd10;
    send(32'h0010_0073, 64'h0000_0000_8000_3008);
    check_bit("ds_to_es_valid ebreak a0", 1'b0, o_ds_to_es_valid);
    @(posedge i_clk);
    i_ms_rd <= 5'd1;  // bits 24:20 of ebreak, not a source
    @(negedge i_clk);
    check_bit("ds_to_es_valid ebreak", 1'b1, o_ds_to_es_valid);
    check_bit("ebreak", 1'b1, o_ebreak);
    @(posedge i_clk);
    i_ms_rd <= 5'd0;
  endtask

  task automatic test_backpressure();
    inst_t a;
    inst_t b;
    pc_t   pa;
    pc_t   pb;
    int    k;
    test_name = "backpressure";
    a  = enc_r(7'd0, 5'd5, 5'd1, 3'b000, 5'd3, `ID_OPC_OP);
    b  = enc_i(12'h010, 5'd1, 3'b000, 5'd2, `ID_OPC_OP_IMM);
    pa = 64'h0000_0000_8000_4000;
    pb = 64'h0000_0000_8000_4004;
    @(posedge i_clk);
    i_es_allowin <= 1'b0;
    send(a, pa);
    @(posedge i_clk);
    i_fs_to_ds_valid <= 1'b1;
    i_fs_inst        <= b;
    i_fs_pc          <= pb;
    for (k = 0; k < 4; k++) begin
      @(negedge i_clk);
      check_bit("ds_allowin", 1'b0, o_ds_allowin);
      check_bit("ds_to_es_valid", 1'b1, o_ds_to_es_valid);
      check_inst("ds_inst", a, o_ds_inst);
      check_pc("ds_pc", pa, o_ds_pc);
    end
    @(posedge i_clk);
    i_es_allowin <= 1'b1;
    @(negedge i_clk);
    check_bit("ds_allowin released", 1'b1, o_ds_allowin);
    @(posedge i_clk);
    i_fs_to_ds_valid <= 1'b0;
    @(negedge i_clk);
    check_bit("ds_to_es_valid next", 1'b1, o_ds_to_es_valid);
    check_inst("ds_inst next", b, o_ds_inst);
    check_pc("ds_pc next", pb, o_ds_pc);
  endtask

  initial begin
    model            = '{default: '0};
    n_checks         = 0;
    n_errors         = 0;
    cycles           = 0;
    i_rst_n          = 1'b0;
    i_fs_to_ds_valid = 1'b0;
    i_fs_inst        = '0;
    i_fs_pc          = '0;
    i_es_allowin     = 1'b1;
    i_es_rd          = '0;
    i_ms_rd          = '0;
    i_ws_rd          = '0;
    i_wb_wen         = 1'b0;
    i_wb_addr        = '0;
    i_wb_data        = '0;
    repeat (4) @(posedge i_clk);
    i_rst_n <= 1'b1;
    test_gpr_read();
    test_formats();
    test_branch();
    test_interlock();
    test_backpressure();
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire
